// File: verilog/pmu_pkg.sv
package pmu_pkg;

    // memory geometry
    localparam int MEM_DATA_WIDTH = 32;
    localparam int MEM_ADDR_WIDTH = 8;

    // header occupies two words ahead of the payload
    localparam int HEADER_WORDS = 2;

    typedef logic [MEM_DATA_WIDTH-1:0] word_t;
    typedef logic [MEM_ADDR_WIDTH-1:0] addr_t;
    typedef logic [15:0]               len_t;
    typedef logic [4:0]                bit_idx_t;
    typedef logic [3:0]                cmd_t;

    localparam cmd_t CMD_PROGRAM = 4'b0001;
    localparam cmd_t CMD_PASS    = 4'b1010;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PROGRAM,
        ST_PASS,
        ST_REPLAY,
        ST_DONE
    } pmu_state_t;

endpackage

// File: verilog/mem_if.sv
`timescale 1ns/100ps

interface mem_if;
    import pmu_pkg::*;

    // write port
    logic  wr_en;
    addr_t wr_addr;
    word_t wr_data;

    // read port, one cycle latency
    addr_t rd_addr;
    word_t rd_data;

    // boot record
    logic  boot_wr;
    addr_t boot_addr_in;
    len_t  boot_len_in;
    addr_t boot_addr;
    len_t  boot_len;

    modport ctrl (
        output wr_en, wr_addr, wr_data, rd_addr, boot_wr, boot_addr_in, boot_len_in,
        input  rd_data, boot_addr, boot_len
    );

    modport mem (
        input  wr_en, wr_addr, wr_data, rd_addr, boot_wr, boot_addr_in, boot_len_in,
        output rd_data, boot_addr, boot_len
    );

endinterface

// File: verilog/bit_counter.sv
`timescale 1ns/100ps

module bit_counter #(
    parameter int data_width = pmu_pkg::MEM_DATA_WIDTH
) (
    input  logic          clk,
    input  logic          rst_i,
    input  logic          en_i,
    input  logic          clr_i,
    output logic          word_done_o,
    output pmu_pkg::len_t word_count_o
);
    import pmu_pkg::*;

    bit_idx_t bit_idx_q;
    len_t     word_cnt_q;
    logic     last_bit;

    assign last_bit = (bit_idx_q == bit_idx_t'(data_width - 1));

    always_ff @(posedge clk)
    begin
        if (rst_i || clr_i)
        begin
            bit_idx_q  <= '0;
            word_cnt_q <= '0;
        end
        else if (en_i)
        begin
            if (last_bit)
            begin
                bit_idx_q  <= '0;
                word_cnt_q <= word_cnt_q + 1'b1;
            end
            else
            begin
                bit_idx_q <= bit_idx_q + 1'b1;
            end
        end
    end

    // strobe on the last counted bit of a word
    assign word_done_o  = en_i && last_bit;
    assign word_count_o = word_cnt_q;

    assert property (@(posedge clk) disable iff (rst_i)
        int'(bit_idx_q) < data_width);

endmodule

// File: verilog/word_sipo.sv
`timescale 1ns/100ps

module word_sipo #(
    parameter int data_width = pmu_pkg::MEM_DATA_WIDTH
) (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           bit_i,
    input  logic           shift_en_i,
    output pmu_pkg::word_t word_o,
    output logic           word_valid_o
);
    import pmu_pkg::*;

    bit_idx_t cnt_q;
    word_t    sr_q;
    logic     valid_q;

    always_ff @(posedge clk)
    begin
        if (rst_i || !shift_en_i)
        begin
            // any gap in the stream restarts the word
            cnt_q   <= '0;
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= (cnt_q == bit_idx_t'(data_width - 1));
            if (cnt_q == bit_idx_t'(data_width - 1))
                cnt_q <= '0;
            else
                cnt_q <= cnt_q + 1'b1;
        end
    end

    // lsb first, so new bits enter at the top
    always_ff @(posedge clk)
    begin
        if (shift_en_i)
            sr_q <= {bit_i, sr_q[$bits(word_t)-1:1]};
    end

    assign word_o       = sr_q;
    assign word_valid_o = valid_q;

endmodule

// File: verilog/nv_memory.sv
`timescale 1ns/100ps

module nv_memory #(
    parameter int addr_width = pmu_pkg::MEM_ADDR_WIDTH
) (
    input logic clk,
    input logic rst_i,
    mem_if.mem  bus
);
    import pmu_pkg::*;

    localparam int DEPTH = 2 ** addr_width;

    word_t mem_q [DEPTH];
    addr_t boot_addr_q;
    len_t  boot_len_q;

    always_ff @(posedge clk)
    begin
        if (bus.wr_en)
            mem_q[bus.wr_addr] <= bus.wr_data;
        bus.rd_data <= mem_q[bus.rd_addr];
    end

    // an empty boot record makes a replay finish at once
    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            boot_addr_q <= '0;
            boot_len_q  <= '0;
        end
        else if (bus.boot_wr)
        begin
            boot_addr_q <= bus.boot_addr_in;
            boot_len_q  <= bus.boot_len_in;
        end
    end

    assign bus.boot_addr = boot_addr_q;
    assign bus.boot_len  = boot_len_q;

    assert property (@(posedge clk) disable iff (rst_i)
        !(bus.boot_wr && bus.wr_en));

endmodule

// File: verilog/word_piso.sv
`timescale 1ns/100ps

module word_piso #(
    parameter int data_width = pmu_pkg::MEM_DATA_WIDTH
) (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           load_i,
    input  pmu_pkg::word_t word_i,
    output logic           bit_o,
    output logic           active_o
);
    import pmu_pkg::*;

    bit_idx_t left_q;
    word_t    sr_q;
    logic     active_q;

    // bits still to come after the current one
    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            active_q <= 1'b0;
            left_q   <= '0;
        end
        else if (load_i)
        begin
            active_q <= 1'b1;
            left_q   <= bit_idx_t'(data_width - 1);
        end
        else if (active_q)
        begin
            if (left_q == '0)
                active_q <= 1'b0;
            else
                left_q <= left_q - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load_i)
            sr_q <= word_i;
        else if (active_q)
            sr_q <= {1'b0, sr_q[$bits(word_t)-1:1]};
    end

    assign bit_o    = active_q && sr_q[0];
    assign active_o = active_q;

    // back-to-back words reload on the last bit only
    assert property (@(posedge clk) disable iff (rst_i)
        load_i |-> !active_q || left_q == '0);

endmodule

// File: verilog/pmu_fsm.sv
`timescale 1ns/100ps

module pmu_fsm (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           en_i,
    input  logic           pwr_up_i,
    input  pmu_pkg::word_t word_i,
    input  logic           word_valid_i,
    input  logic           word_done_i,
    input  pmu_pkg::len_t  word_count_i,
    output logic           count_en_o,
    output logic           count_clr_o,
    output logic           shift_en_o,
    output logic           piso_load_o,
    output pmu_pkg::word_t piso_word_o,
    output logic           complete_o,
    mem_if.ctrl            mem
);
    import pmu_pkg::*;

    pmu_state_t state_q;
    pmu_state_t state_d;
    logic       en_q;
    logic       cmd_start;
    logic       in_stream;
    logic       hdr_last;
    logic       cmd_known;
    logic       replay_go;
    logic       rd_issue_q;
    logic       rd_valid_q;
    cmd_t       cmd_q;
    addr_t      start_q;
    len_t       last_count_q;
    len_t       hdr_len;
    len_t       payload_idx;

    // a command starts on a rising en_i only
    assign cmd_start = (state_q == ST_IDLE) && en_i && !en_q;
    assign in_stream = en_i &&
        (state_q == ST_HEADER || state_q == ST_PROGRAM || state_q == ST_PASS);

    // second header word carries the length in its low half
    assign hdr_last  = (state_q == ST_HEADER) && word_valid_i &&
        (word_count_i == len_t'(HEADER_WORDS));
    assign hdr_len   = word_i[15:0];
    assign cmd_known = (cmd_q == CMD_PROGRAM) || (cmd_q == CMD_PASS);
    assign replay_go = (state_q == ST_IDLE) && (state_d == ST_REPLAY);

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            state_q    <= ST_IDLE;
            en_q       <= 1'b0;
            rd_issue_q <= 1'b0;
            rd_valid_q <= 1'b0;
        end
        else
        begin
            state_q    <= state_d;
            en_q       <= en_i;
            // new read address at each word boundary of a replay
            rd_issue_q <= replay_go || (state_q == ST_REPLAY && word_done_i);
            rd_valid_q <= rd_issue_q;
        end
    end

    // header fields
    always_ff @(posedge clk)
    begin
        if (state_q == ST_HEADER && word_valid_i)
        begin
            if (hdr_last)
            begin
                last_count_q <= len_t'(HEADER_WORDS) + hdr_len;
            end
            else
            begin
                cmd_q   <= word_i[3:0];
                start_q <= word_i[4 +: MEM_ADDR_WIDTH];
            end
        end
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:
            begin
                if (cmd_start)
                    state_d = ST_HEADER;
                else if (pwr_up_i)
                    state_d = (mem.boot_len == '0) ? ST_DONE : ST_REPLAY;
            end
            ST_HEADER:
            begin
                if (hdr_last)
                begin
                    if (!cmd_known)
                        state_d = ST_IDLE;
                    else if (hdr_len == '0)
                        state_d = ST_DONE;
                    else if (cmd_q == CMD_PROGRAM)
                        state_d = ST_PROGRAM;
                    else
                        state_d = ST_PASS;
                end
                else if (!en_i)
                begin
                    state_d = ST_IDLE;
                end
            end
            ST_PROGRAM, ST_PASS:
            begin
                if (word_valid_i && word_count_i == last_count_q)
                    state_d = ST_DONE;
                else if (!en_i && word_count_i < last_count_q)
                    state_d = ST_IDLE;
            end
            ST_REPLAY:
            begin
                if (rd_valid_q && word_count_i == mem.boot_len)
                    state_d = ST_DONE;
            end
            default:
            begin
                state_d = ST_IDLE;
            end
        endcase
    end

    assign shift_en_o  = cmd_start || in_stream;
    assign count_en_o  = shift_en_o || (state_q == ST_REPLAY);
    assign count_clr_o = (state_q == ST_IDLE && !cmd_start) || (state_q == ST_DONE);
    assign complete_o  = (state_q == ST_DONE);

    // payload word index from the running word count
    assign payload_idx = word_count_i - len_t'(HEADER_WORDS + 1);

    assign mem.wr_en        = (state_q == ST_PROGRAM) && word_valid_i;
    assign mem.wr_addr      = start_q + addr_t'(payload_idx);
    assign mem.wr_data      = word_i;
    assign mem.rd_addr      = mem.boot_addr + addr_t'(word_count_i);
    assign mem.boot_wr      = hdr_last && (cmd_q == CMD_PROGRAM);
    assign mem.boot_addr_in = start_q;
    assign mem.boot_len_in  = hdr_len;

    assign piso_load_o = ((state_q == ST_PASS) && word_valid_i) ||
        ((state_q == ST_REPLAY) && rd_valid_q && word_count_i < mem.boot_len);
    assign piso_word_o = (state_q == ST_REPLAY) ? mem.rd_data : word_i;

    assert property (@(posedge clk) disable iff (rst_i)
        mem.wr_en |-> state_q == ST_PROGRAM);

    assert property (@(posedge clk) disable iff (rst_i)
        piso_load_o |-> state_q != ST_IDLE);

endmodule

// File: verilog/pmu_top.sv
`timescale 1ns/100ps

module pmu_top #(
    parameter int data_width = pmu_pkg::MEM_DATA_WIDTH,
    parameter int addr_width = pmu_pkg::MEM_ADDR_WIDTH
) (
    input  logic clk,
    input  logic rst_i,
    input  logic data_i,
    input  logic en_i,
    input  logic pwr_up_i,
    output logic sc_data_o,
    output logic sc_en_o,
    output logic program_complete_o
);
    import pmu_pkg::*;

    word_t sipo_word;
    logic  sipo_valid;
    logic  word_done;
    len_t  word_count;
    logic  count_en;
    logic  count_clr;
    logic  shift_en;
    logic  piso_load;
    word_t piso_word;

    mem_if mem_bus ();

    pmu_fsm fsm_inst (
        .clk          (clk),
        .rst_i        (rst_i),
        .en_i         (en_i),
        .pwr_up_i     (pwr_up_i),
        .word_i       (sipo_word),
        .word_valid_i (sipo_valid),
        .word_done_i  (word_done),
        .word_count_i (word_count),
        .count_en_o   (count_en),
        .count_clr_o  (count_clr),
        .shift_en_o   (shift_en),
        .piso_load_o  (piso_load),
        .piso_word_o  (piso_word),
        .complete_o   (program_complete_o),
        .mem          (mem_bus.ctrl)
    );

    bit_counter #(
        .data_width (data_width)
    ) counter_inst (
        .clk          (clk),
        .rst_i        (rst_i),
        .en_i         (count_en),
        .clr_i        (count_clr),
        .word_done_o  (word_done),
        .word_count_o (word_count)
    );

    word_sipo #(
        .data_width (data_width)
    ) sipo_inst (
        .clk          (clk),
        .rst_i        (rst_i),
        .bit_i        (data_i),
        .shift_en_i   (shift_en),
        .word_o       (sipo_word),
        .word_valid_o (sipo_valid)
    );

    nv_memory #(
        .addr_width (addr_width)
    ) memory_inst (
        .clk   (clk),
        .rst_i (rst_i),
        .bus   (mem_bus.mem)
    );

    // scan chain sits outside, fed straight from the shifter
    word_piso #(
        .data_width (data_width)
    ) piso_inst (
        .clk      (clk),
        .rst_i    (rst_i),
        .load_i   (piso_load),
        .word_i   (piso_word),
        .bit_o    (sc_data_o),
        .active_o (sc_en_o)
    );

endmodule

// File: tests/pmu_checker.sv
`timescale 1ns/100ps

module pmu_checker (
    input logic clk,
    input logic rst_i,
    input logic sc_data_i,
    input logic sc_en_i,
    input logic complete_i
);
    import pmu_pkg::*;

    logic exp_bits_q [$];
    logic exp_bit;
    int   pulses_exp    = 0;
    int   pulses_seen   = 0;
    int   bits_seen     = 0;
    int   errors        = 0;
    int   errors_before = 0;
    int   tests_run     = 0;

    // scan chain takes the word lsb first
    task automatic expect_word(input word_t w);
        int i;
        for (i = 0; i < $bits(word_t); i++)
            exp_bits_q.push_back(w[i]);
    endtask

    task automatic expect_pulse();
        pulses_exp++;
    endtask

    always @(posedge clk)
    begin
        if (!rst_i)
        begin
            if (sc_en_i === 1'b1)
            begin
                if (exp_bits_q.size() == 0)
                begin
                    $display("scan bit at %0t while no scan output was expected", $time);
                    errors++;
                end
                else
                begin
                    exp_bit = exp_bits_q.pop_front();
                    bits_seen++;
                    if (sc_data_i !== exp_bit)
                    begin
                        $display("Mismatch at %0t: sc_data_o = %b, expected %b",
                                 $time, sc_data_i, exp_bit);
                        errors++;
                    end
                end
            end
            else if (sc_en_i === 1'b0)
            begin
                // scan data sits low between words
                if (sc_data_i !== 1'b0)
                begin
                    $display("Mismatch at %0t: sc_data_o = %b, expected %b",
                             $time, sc_data_i, 1'b0);
                    errors++;
                end
            end
            else
            begin
                $display("sc_en_o is unknown at %0t", $time);
                errors++;
            end
            if (complete_i === 1'b1)
            begin
                if (pulses_seen >= pulses_exp)
                begin
                    $display("completion pulse at %0t that no command called for", $time);
                    errors++;
                end
                pulses_seen++;
            end
            else if (complete_i !== 1'b0)
            begin
                $display("program_complete_o is unknown at %0t", $time);
                errors++;
            end
        end
    end

    // counters move on the rising edge, so look at them on the falling one
    task automatic wait_for_expected(input int timeout_cycles);
        int n;
        n = 0;
        while ((exp_bits_q.size() != 0 || pulses_seen < pulses_exp) && n < timeout_cycles)
        begin
            @(negedge clk);
            n++;
        end
        if (exp_bits_q.size() != 0 || pulses_seen < pulses_exp)
        begin
            $display("timed out with %0d scan bits and %0d completion pulses still missing",
                     exp_bits_q.size(), pulses_exp - pulses_seen);
            errors++;
            exp_bits_q.delete();
            pulses_seen = pulses_exp;
        end
    endtask

    // stray activity is flagged by the monitor while this runs
    task automatic watch_quiet(input int cycles);
        int n;
        for (n = 0; n < cycles; n++)
            @(negedge clk);
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (errors == errors_before)
            $display("test %s: ok", name);
        else
            $display("test %s: FAILED with %0d errors", name, errors - errors_before);
        errors_before = errors;
    endtask

    task automatic report_counts();
        $display("tests run %0d, scan bits checked %0d, completion pulses %0d, errors %0d",
                 tests_run, bits_seen, pulses_seen, errors);
    endtask

endmodule

// File: tests/pmu_tb.sv
`timescale 1ns/100ps

module pmu_tb;
    import pmu_pkg::*;

    localparam int SCAN_TIMEOUT    = 2000;
    localparam int QUIET_CYCLES    = 40;
    localparam int WATCHDOG_CYCLES = 30000;

    logic clk;
    logic rst_i;
    logic data_i;
    logic en_i;
    logic pwr_up_i;
    logic sc_data_o;
    logic sc_en_o;
    logic program_complete_o;

    integer seed;
    word_t  model_mem [2**MEM_ADDR_WIDTH];
    addr_t  boot_addr_m;
    len_t   boot_len_m;
    word_t  payload_q [$];

    pmu_top #(
        .data_width (MEM_DATA_WIDTH),
        .addr_width (MEM_ADDR_WIDTH)
    ) pmu_top_inst (
        .clk                (clk),
        .rst_i              (rst_i),
        .data_i             (data_i),
        .en_i               (en_i),
        .pwr_up_i           (pwr_up_i),
        .sc_data_o          (sc_data_o),
        .sc_en_o            (sc_en_o),
        .program_complete_o (program_complete_o)
    );

    pmu_checker checker_inst (
        .clk        (clk),
        .rst_i      (rst_i),
        .sc_data_i  (sc_data_o),
        .sc_en_i    (sc_en_o),
        .complete_i (program_complete_o)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic int pick_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // fields laid over random filler in the ignored bits
    function automatic logic [63:0] make_header(input cmd_t code, input addr_t start,
                                                input len_t len);
        logic [63:0] hdr;
        hdr        = {$random(seed), $random(seed)};
        hdr[3:0]   = code;
        hdr[11:4]  = start;
        hdr[47:32] = len;
        return hdr;
    endfunction

    task automatic send_bit(input logic b);
        @(posedge clk);
        data_i <= b;
        en_i   <= 1'b1;
    endtask

    task automatic end_stream();
        @(posedge clk);
        data_i <= 1'b0;
        en_i   <= 1'b0;
    endtask

    task automatic fill_payload(input int count);
        int i;
        payload_q.delete();
        for (i = 0; i < count; i++)
            payload_q.push_back($random(seed));
    endtask

    // header bits, then the payload words, lsb first
    task automatic send_command(input logic [63:0] hdr, input int hdr_bits);
        int    i;
        int    w;
        word_t word;
        for (i = 0; i < hdr_bits; i++)
            send_bit(hdr[i]);
        if (hdr_bits == 64)
        begin
            for (w = 0; w < payload_q.size(); w++)
            begin
                word = payload_q[w];
                for (i = 0; i < $bits(word_t); i++)
                    send_bit(word[i]);
            end
        end
        end_stream();
    endtask

    task automatic program_memory(input addr_t start, input int len);
        int    i;
        addr_t a;
        fill_payload(len);
        for (i = 0; i < len; i++)
        begin
            a = start + addr_t'(i);
            model_mem[a] = payload_q[i];
        end
        boot_addr_m = start;
        boot_len_m  = len_t'(len);
        checker_inst.expect_pulse();
        send_command(make_header(CMD_PROGRAM, start, len_t'(len)), 64);
    endtask

    task automatic pass_words(input int count);
        int i;
        fill_payload(count);
        for (i = 0; i < count; i++)
            checker_inst.expect_word(payload_q[i]);
        checker_inst.expect_pulse();
        send_command(make_header(CMD_PASS, addr_t'($random(seed)), len_t'(count)), 64);
    endtask

    task automatic power_up_replay();
        int    i;
        addr_t a;
        for (i = 0; i < int'(boot_len_m); i++)
        begin
            a = boot_addr_m + addr_t'(i);
            checker_inst.expect_word(model_mem[a]);
        end
        checker_inst.expect_pulse();
        @(posedge clk);
        pwr_up_i <= 1'b1;
        @(posedge clk);
        pwr_up_i <= 1'b0;
    endtask

    task automatic finish_test(input string name);
        checker_inst.wait_for_expected(SCAN_TIMEOUT);
        checker_inst.watch_quiet(QUIET_CYCLES);
        checker_inst.close_test(name);
    endtask

    initial
    begin
        int    i;
        int    len;
        int    len_b;
        addr_t start;
        addr_t start_b;
        cmd_t  bad_code;
        seed     = 97083;
        rst_i    <= 1'b1;
        data_i   <= 1'b0;
        en_i     <= 1'b0;
        pwr_up_i <= 1'b0;
        for (i = 0; i < 10; i++)
            @(posedge clk);
        rst_i <= 1'b0;

        finish_test("reset_idle");

        start = addr_t'($random(seed));
        len   = pick_range(2, 4);
        program_memory(start, len);
        checker_inst.wait_for_expected(SCAN_TIMEOUT);
        checker_inst.watch_quiet(4);
        power_up_replay();
        finish_test("program_replay");

        pass_words(pick_range(1, 5));
        finish_test("pass_through");

        bad_code = cmd_t'($random(seed));
        while (bad_code == CMD_PROGRAM || bad_code == CMD_PASS)
            bad_code = cmd_t'($random(seed));
        fill_payload(2);
        send_command(make_header(bad_code, addr_t'($random(seed)), 16'd2), 64);
        checker_inst.watch_quiet(QUIET_CYCLES);
        // en_i drops partway through a pass header
        send_command(make_header(CMD_PASS, 8'h00, 16'd1), pick_range(10, 60));
        checker_inst.watch_quiet(QUIET_CYCLES);
        pass_words(pick_range(1, 3));
        finish_test("bad_input");

        start_b = addr_t'($random(seed));
        while (start_b == start)
            start_b = addr_t'($random(seed));
        len_b = pick_range(1, 5);
        while (len_b == len)
            len_b = pick_range(1, 5);
        program_memory(start_b, len_b);
        checker_inst.wait_for_expected(SCAN_TIMEOUT);
        checker_inst.watch_quiet(4);
        power_up_replay();
        finish_test("reprogram_replay");

        checker_inst.report_counts();
        if (checker_inst.errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * 100);
        $display("simulation ran past its time limit before the last test finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: sources.f
verilog/pmu_pkg.sv
verilog/mem_if.sv
verilog/bit_counter.sv
verilog/word_sipo.sv
verilog/nv_memory.sv
verilog/word_piso.sv
verilog/pmu_fsm.sv
verilog/pmu_top.sv
tests/pmu_checker.sv
tests/pmu_tb.sv
